/* src/radar_pkg.sv */
`default_nettype none

package radar_pkg;

	localparam int unsigned frame_bits = 408;

	// wire order, first field is sent first
	typedef struct packed {
		logic [63:0] sys_time;   // system time preset
		logic [47:0] freq;
		logic [47:0] freq_step;
		logic [31:0] freq_rate;  // clk cycles per chirp step
		logic [63:0] time_start; // burst start, in system time
		logic [15:0] n_pulse;
		logic [7:0]  pulse_type;
		logic [31:0] ti;         // pulse width
		logic [31:0] tp;         // pulse period
		logic [31:0] tblank1;    // blanking before the pulse
		logic [31:0] tblank2;    // blanking after the pulse
	} frame_t;

	typedef struct packed {
		logic [63:0] time_start;
		logic [15:0] n_pulse;
		logic [31:0] ti;
		logic [31:0] tp;
		logic [31:0] tblank1;
		logic [31:0] tblank2;
	} timing_cmd_t;

	typedef struct packed {
		logic [47:0] freq;
		logic [47:0] freq_step;
		logic [31:0] freq_rate;
		logic [7:0]  pulse_type;
	} freq_cmd_t;

	localparam logic [7:0] type_fixed = 8'd0; // constant frequency
	localparam logic [7:0] type_chirp = 8'd1; // steps inside each pulse
	localparam logic [7:0] type_hop   = 8'd2; // one step per pulse

endpackage

`default_nettype wire

/* src/spi_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_frame_rx #(
	parameter int unsigned sync_stages = 2
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              sclk,
	input  logic              cs,
	input  logic              mosi,
	output radar_pkg::frame_t frame,
	output logic              frame_valid,
	output logic              frame_error
);

	localparam int unsigned cnt_w = $clog2(radar_pkg::frame_bits + 2);
	localparam logic [cnt_w-1:0] cnt_full = cnt_w'(radar_pkg::frame_bits);
	localparam logic [cnt_w-1:0] cnt_sat = cnt_w'(radar_pkg::frame_bits + 1);

	logic [sync_stages-1:0] sclk_sync;
	logic [sync_stages-1:0] cs_sync;
	logic [sync_stages-1:0] mosi_sync;
	logic sclk_d;
	logic cs_d;
	logic sclk_s;
	logic cs_s;
	logic mosi_s;
	logic sclk_rise;
	logic cs_rise;
	logic cs_fall;
	logic [radar_pkg::frame_bits-1:0] shreg;
	logic [cnt_w-1:0] bit_cnt;

	assign sclk_s = sclk_sync[sync_stages-1];
	assign cs_s = cs_sync[sync_stages-1];
	assign mosi_s = mosi_sync[sync_stages-1]; // same delay as sclk, stays in step
	assign sclk_rise = sclk_s & ~sclk_d;
	assign cs_rise = cs_s & ~cs_d;
	assign cs_fall = ~cs_s & cs_d;
	assign frame = radar_pkg::frame_t'(shreg);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sclk_sync <= '0;
			cs_sync <= '1; // CS idles high
			mosi_sync <= '0;
			sclk_d <= 1'b0;
			cs_d <= 1'b1;
			bit_cnt <= '0;
			frame_valid <= 1'b0;
			frame_error <= 1'b0;
		end
		else
		begin
			sclk_sync <= {sclk_sync[sync_stages-2:0], sclk};
			cs_sync <= {cs_sync[sync_stages-2:0], cs};
			mosi_sync <= {mosi_sync[sync_stages-2:0], mosi};
			sclk_d <= sclk_s;
			cs_d <= cs_s;
			if (cs_fall)
				bit_cnt <= '0; // new frame
			else if (sclk_rise && !cs_s && bit_cnt != cnt_sat)
				bit_cnt <= bit_cnt + 1'b1;
			frame_valid <= cs_rise && (bit_cnt == cnt_full);
			frame_error <= cs_rise && (bit_cnt != cnt_full);
		end
	end

	always_ff @(posedge clk)
	begin
		if (sclk_rise && !cs_s)
			shreg <= {shreg[radar_pkg::frame_bits-2:0], mosi_s}; // msb first
	end

endmodule

`default_nettype wire

/* src/cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   frame_valid,
	input  radar_pkg::frame_t      frame,
	output radar_pkg::timing_cmd_t timing,
	output radar_pkg::freq_cmd_t   fcmd,
	output logic [63:0]            time_preset,
	output logic                   cmd_valid,
	output logic                   cmd_reject
);

	logic [33:0] span; // tblank1 + ti + tblank2, no overflow
	logic type_ok;
	logic bad;

	always_comb
	begin
		span = {2'b00, frame.tblank1} + {2'b00, frame.ti} + {2'b00, frame.tblank2};
		type_ok = (frame.pulse_type == radar_pkg::type_fixed) ||
			(frame.pulse_type == radar_pkg::type_chirp) ||
			(frame.pulse_type == radar_pkg::type_hop);
		bad = (frame.n_pulse == '0) || (frame.ti == '0) || (frame.ti >= frame.tp) ||
			(span > {2'b00, frame.tp}) || !type_ok;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cmd_valid <= 1'b0;
			cmd_reject <= 1'b0;
		end
		else
		begin
			cmd_valid <= frame_valid && !bad;
			cmd_reject <= frame_valid && bad;
		end
	end

	// fields are only meaningful with cmd_valid
	always_ff @(posedge clk)
	begin
		if (frame_valid)
		begin
			time_preset <= frame.sys_time;
			timing.time_start <= frame.time_start;
			timing.n_pulse <= frame.n_pulse;
			timing.ti <= frame.ti;
			timing.tp <= frame.tp;
			timing.tblank1 <= frame.tblank1;
			timing.tblank2 <= frame.tblank2;
			fcmd.freq <= frame.freq;
			fcmd.freq_step <= frame.freq_step;
			fcmd.freq_rate <= frame.freq_rate;
			fcmd.pulse_type <= frame.pulse_type;
		end
	end

endmodule

`default_nettype wire

/* src/cmd_shadow.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_shadow #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     load,
	input  payload_t din,
	input  logic     busy,
	output payload_t dout,
	output logic     applied
);

	payload_t pend;
	logic pending;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dout <= '0;
			pending <= 1'b0;
			applied <= 1'b0;
		end
		else
		begin
			applied <= 1'b0;
			if (load && !busy)
			begin
				dout <= din; // consumer idle, straight through
				pending <= 1'b0;
				applied <= 1'b1;
			end
			else if (load)
				pending <= 1'b1; // newest one wins
			else if (pending && !busy)
			begin
				dout <= pend;
				pending <= 1'b0;
				applied <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			pend <= din;
	end

endmodule

`default_nettype wire

/* src/pulse_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module pulse_sequencer #(
	parameter int unsigned time_width = 64
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   time_load,
	input  logic [time_width-1:0]  time_preset,
	input  logic                   arm,
	input  radar_pkg::timing_cmd_t timing,
	output logic [time_width-1:0]  sys_time,
	output logic                   time_update,
	output logic                   busy,
	output logic                   pulse,
	output logic                   blank,
	output logic                   pulse_start
);

	logic [time_width-1:0] time_n;
	logic armed;
	logic armed_n;
	logic running;
	logic run_n;
	logic [31:0] phase;
	logic [31:0] phase_n;
	logic [15:0] pcount;
	logic [15:0] pcount_n;
	logic start_hit;
	logic last_slot;
	logic [32:0] blank_head; // end of blanking after the pulse
	logic [31:0] blank_tail; // start of blanking before the next pulse

	assign blank_head = {1'b0, timing.ti} + {1'b0, timing.tblank2};
	assign blank_tail = timing.tp - timing.tblank1;

	// next state, so the gates come out registered in line with sys_time
	always_comb
	begin
		time_n = time_load ? time_preset : sys_time + 1'b1;
		start_hit = (armed || arm) && !running &&
			(time_n == timing.time_start[time_width-1:0]);
		last_slot = (phase == timing.tp - 32'd1);
		armed_n = armed;
		run_n = running;
		phase_n = phase;
		pcount_n = pcount;
		if (start_hit)
		begin
			armed_n = 1'b0;
			run_n = 1'b1;
			phase_n = '0;
			pcount_n = '0;
		end
		else if (running)
		begin
			if (last_slot)
			begin
				phase_n = '0;
				pcount_n = pcount + 16'd1;
				if (pcount == timing.n_pulse - 16'd1)
					run_n = 1'b0; // last period done
			end
			else
				phase_n = phase + 32'd1;
		end
		else if (arm)
			armed_n = 1'b1;
		else if (time_load)
			armed_n = 1'b0; // start time may now be unreachable, drop it
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sys_time <= '0;
			time_update <= 1'b0;
			armed <= 1'b0;
			running <= 1'b0;
			phase <= '0;
			pcount <= '0;
			busy <= 1'b0;
			pulse <= 1'b0;
			blank <= 1'b0;
			pulse_start <= 1'b0;
		end
		else
		begin
			sys_time <= time_n;
			time_update <= time_load;
			armed <= armed_n;
			running <= run_n;
			phase <= phase_n;
			pcount <= pcount_n;
			busy <= armed_n || run_n;
			pulse <= run_n && (phase_n < timing.ti);
			blank <= run_n && (({1'b0, phase_n} < blank_head) || (phase_n >= blank_tail));
			pulse_start <= run_n && (phase_n == '0);
		end
	end

endmodule

`default_nettype wire

/* src/freq_sweep.sv */
`timescale 1ns/1ps
`default_nettype none

module freq_sweep (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 pulse_start,
	input  logic                 pulse,
	input  radar_pkg::freq_cmd_t fcmd,
	output logic [47:0]          freq_word
);

	logic started; // first pulse of the burst seen
	logic [31:0] rate_cnt; // cycles spent on the current chirp step

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			freq_word <= '0;
			started <= 1'b0;
			rate_cnt <= '0;
		end
		else if (pulse_start)
		begin
			started <= 1'b1;
			rate_cnt <= 32'd1;
			if (started && fcmd.pulse_type == radar_pkg::type_hop)
				freq_word <= freq_word + fcmd.freq_step;
			else
				freq_word <= fcmd.freq; // chirp restarts, first hop starts here
		end
		else if (!started)
			freq_word <= fcmd.freq;
		else
		begin
			case (fcmd.pulse_type)
				radar_pkg::type_chirp:
				begin
					if (pulse)
					begin
						if (rate_cnt >= fcmd.freq_rate)
						begin
							freq_word <= freq_word + fcmd.freq_step;
							rate_cnt <= 32'd1;
						end
						else
							rate_cnt <= rate_cnt + 32'd1;
					end
				end
				radar_pkg::type_hop:
					freq_word <= freq_word; // hold between pulses
				default:
					freq_word <= fcmd.freq;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/radar_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module radar_ctrl_top #(
	parameter int unsigned sync_stages = 2,
	parameter int unsigned time_width = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  sclk,
	input  logic                  cs,
	input  logic                  mosi,
	output logic [time_width-1:0] sys_time,
	output logic                  time_update,
	output logic                  busy,
	output logic                  pulse,
	output logic                  blank,
	output logic [47:0]           freq_word,
	output logic                  frame_error,
	output logic                  cmd_reject
);

	radar_pkg::frame_t frame;
	radar_pkg::timing_cmd_t timing_cmd;
	radar_pkg::timing_cmd_t timing_act;
	radar_pkg::freq_cmd_t freq_cmd;
	radar_pkg::freq_cmd_t freq_act;
	logic frame_valid;
	logic [63:0] time_preset;
	logic cmd_valid;
	logic arm;
	logic freq_applied;
	logic sweep_rst;
	logic [time_width-1:0] seq_time;
	logic seq_update;
	logic seq_busy;
	logic seq_pulse;
	logic seq_blank;
	logic seq_start;

	assign sweep_rst = rst | freq_applied; // new command restarts the sweep

	spi_frame_rx #(.sync_stages(sync_stages)) spi_frame_rx_i (
		.clk(clk), .rst(rst), .sclk(sclk), .cs(cs), .mosi(mosi),
		.frame(frame), .frame_valid(frame_valid), .frame_error(frame_error)
	);

	cmd_decode cmd_decode_i (
		.clk(clk), .rst(rst), .frame_valid(frame_valid), .frame(frame),
		.timing(timing_cmd), .fcmd(freq_cmd), .time_preset(time_preset),
		.cmd_valid(cmd_valid), .cmd_reject(cmd_reject)
	);

	cmd_shadow #(.payload_t(radar_pkg::timing_cmd_t)) timing_shadow_i (
		.clk(clk), .rst(rst), .load(cmd_valid), .din(timing_cmd),
		.busy(seq_busy), .dout(timing_act), .applied(arm)
	);

	cmd_shadow #(.payload_t(radar_pkg::freq_cmd_t)) freq_shadow_i (
		.clk(clk), .rst(rst), .load(cmd_valid), .din(freq_cmd),
		.busy(seq_busy), .dout(freq_act), .applied(freq_applied)
	);

	pulse_sequencer #(.time_width(time_width)) pulse_sequencer_i (
		.clk(clk), .rst(rst), .time_load(cmd_valid),
		.time_preset(time_preset[time_width-1:0]), .arm(arm), .timing(timing_act),
		.sys_time(seq_time), .time_update(seq_update), .busy(seq_busy),
		.pulse(seq_pulse), .blank(seq_blank), .pulse_start(seq_start)
	);

	freq_sweep freq_sweep_i (
		.clk(clk), .rst(sweep_rst), .pulse_start(seq_start), .pulse(seq_pulse),
		.fcmd(freq_act), .freq_word(freq_word)
	);

	// one stage to line up with freq_word
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sys_time <= '0;
			time_update <= 1'b0;
			busy <= 1'b0;
			pulse <= 1'b0;
			blank <= 1'b0;
		end
		else
		begin
			sys_time <= seq_time;
			time_update <= seq_update;
			busy <= seq_busy;
			pulse <= seq_pulse;
			blank <= seq_blank;
		end
	end

endmodule

`default_nettype wire

/* tests/radar_ctrl_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module radar_ctrl_asserts (
	input logic clk,
	input logic rst,
	input logic pulse,
	input logic blank,
	input logic busy,
	input logic time_update,
	input logic frame_error,
	input logic cmd_reject
);

	pulse_in_blank: assert property (@(posedge clk) disable iff (rst) pulse |-> blank)
		else $error("pulse high outside the blanking gate");

	pulse_in_burst: assert property (@(posedge clk) disable iff (rst) pulse |-> busy)
		else $error("pulse high while the sequencer is idle");

	update_one_cycle: assert property (@(posedge clk) disable iff (rst)
		time_update |=> !time_update)
		else $error("time_update longer than one cycle");

	// a rejected or broken frame never presets the time
	no_update_on_error: assert property (@(posedge clk) disable iff (rst)
		!(time_update && (frame_error || cmd_reject)))
		else $error("time_update together with frame_error or cmd_reject");

endmodule

bind radar_ctrl_top radar_ctrl_asserts radar_ctrl_asserts_i (
	.clk(clk),
	.rst(rst),
	.pulse(pulse),
	.blank(blank),
	.busy(busy),
	.time_update(time_update),
	.frame_error(frame_error),
	.cmd_reject(cmd_reject)
);

`default_nettype wire

/* tests/radar_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module radar_ctrl_tb;

	typedef struct packed {
		logic        pulse;
		logic        blank;
		logic [47:0] freq;
	} expect_t;

	logic clk;
	logic rst;
	logic sclk;
	logic cs;
	logic mosi;
	logic [63:0] sys_time;
	logic time_update;
	logic busy;
	logic pulse;
	logic blank;
	logic [47:0] freq_word;
	logic frame_error;
	logic cmd_reject;

	integer seed;
	int value_errors;
	int timeout_errors;
	bit timed_out;
	radar_pkg::frame_t burst_q[$]; // accepted frames, oldest burst first
	bit in_burst;
	logic [63:0] vt; // burst time, keeps counting through a preset
	int pulse_cnt;
	logic pulse_d;
	int bursts_done;

	radar_ctrl_top radar_ctrl_top_i (
		.clk(clk), .rst(rst), .sclk(sclk), .cs(cs), .mosi(mosi),
		.sys_time(sys_time), .time_update(time_update), .busy(busy),
		.pulse(pulse), .blank(blank), .freq_word(freq_word),
		.frame_error(frame_error), .cmd_reject(cmd_reject)
	);

	always #50 clk = ~clk;

	// expected gates and frequency at time t of the burst described by f
	function automatic expect_t ref_model(input radar_pkg::frame_t f, input logic [63:0] t);
		expect_t r;
		logic [63:0] e;
		logic [63:0] k;
		logic [63:0] p;
		logic [63:0] steps;
		e = t - f.time_start;
		k = e / {32'd0, f.tp};
		p = e % {32'd0, f.tp};
		r.pulse = (p < {32'd0, f.ti});
		r.blank = (p < {32'd0, f.ti} + {32'd0, f.tblank2}) ||
			(p >= {32'd0, f.tp} - {32'd0, f.tblank1});
		case (f.pulse_type)
			radar_pkg::type_chirp:
			begin
				if (p < {32'd0, f.ti})
					steps = p / {32'd0, f.freq_rate};
				else
					steps = ({32'd0, f.ti} - 64'd1) / {32'd0, f.freq_rate}; // held after pulse
			end
			radar_pkg::type_hop:
				steps = k;
			default:
				steps = 64'd0;
		endcase
		r.freq = f.freq + f.freq_step * steps[47:0];
		return r;
	endfunction

	function automatic int unsigned draw(input int unsigned n);
		draw = $unsigned($random(seed)) % n;
	endfunction

	task automatic check_time(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_gate(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_freq(input logic [47:0] got, input logic [47:0] exp, input string what);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// random legal command, small gates so bursts stay short
	task automatic make_frame(input logic [7:0] ptype, output radar_pkg::frame_t f);
		f.sys_time = {$random(seed), $random(seed)};
		f.freq = 48'({$random(seed), $random(seed)});
		f.freq_step = 48'({$random(seed), $random(seed)});
		f.freq_rate = 32'(1 + draw(3));
		f.time_start = f.sys_time + 64'(20 + draw(20));
		f.n_pulse = 16'(2 + draw(3));
		f.pulse_type = ptype;
		f.ti = 32'(1 + draw(6));
		f.tblank1 = 32'(draw(3));
		f.tblank2 = 32'(draw(3));
		f.tp = f.ti + f.tblank1 + f.tblank2 + 32'(1 + draw(5));
	endtask

	task automatic send_frame(input radar_pkg::frame_t f, input int nbits);
		int i;
		logic b;
		@(posedge clk);
		cs <= 1'b0;
		repeat (4) @(posedge clk);
		for (i = 0; i < nbits; i++)
		begin
			b = (i < int'(radar_pkg::frame_bits)) ? f[int'(radar_pkg::frame_bits) - 1 - i] : 1'b0;
			mosi <= b; // set up while sclk low
			sclk <= 1'b0;
			repeat (4) @(posedge clk);
			sclk <= 1'b1;
			repeat (4) @(posedge clk);
		end
		sclk <= 1'b0;
		repeat (4) @(posedge clk);
		cs <= 1'b1;
	endtask

	// which: 0 time_update, 1 cmd_reject, 2 frame_error
	task automatic wait_strobe(input int which, input int limit, input string what);
		int n;
		bit seen;
		n = 0;
		seen = 1'b0;
		if (!timed_out)
		begin
			while (!seen && n < limit)
			begin
				@(negedge clk);
				n++;
				case (which)
					0: seen = (time_update === 1'b1);
					1: seen = (cmd_reject === 1'b1);
					default: seen = (frame_error === 1'b1);
				endcase
				if (which != 0)
					check_flag(time_update, 1'b0, "unexpected time_update");
				if (which != 1)
					check_flag(cmd_reject, 1'b0, "unexpected cmd_reject");
				if (which != 2)
					check_flag(frame_error, 1'b0, "unexpected frame_error");
			end
			if (!seen)
			begin
				timeout_errors++;
				timed_out = 1'b1;
				$display("timeout: no %s within %0d cycles", what, limit);
			end
		end
	endtask

	task automatic wait_bursts(input int target, input int limit);
		int n;
		n = 0;
		if (!timed_out)
		begin
			while (bursts_done < target && n < limit)
			begin
				@(negedge clk);
				n++;
			end
			if (bursts_done < target)
			begin
				timeout_errors++;
				timed_out = 1'b1;
				$display("timeout: burst %0d did not finish within %0d cycles", target, limit);
			end
		end
	endtask

	task automatic accept_frame(input radar_pkg::frame_t f);
		burst_q.push_back(f);
		send_frame(f, radar_pkg::frame_bits);
		wait_strobe(0, 50, "time_update");
		if (!timed_out)
			check_time(sys_time, f.sys_time, "sys_time at preset");
	endtask

	// time runs on by one, nothing starts
	task automatic watch_quiet(input int cycles);
		logic [63:0] prev;
		int n;
		@(negedge clk);
		prev = sys_time;
		for (n = 0; n < cycles; n++)
		begin
			@(negedge clk);
			check_time(sys_time, prev + 64'd1, "sys_time continuity");
			check_flag(busy, 1'b0, "busy while idle");
			check_flag(time_update, 1'b0, "time_update while idle");
			prev = sys_time;
		end
	endtask

	always @(negedge clk)
	begin : compare
		expect_t e;
		if (!rst)
		begin
			if (!in_burst && busy && burst_q.size() > 0 && sys_time == burst_q[0].time_start)
			begin
				in_burst = 1'b1;
				vt = sys_time;
				pulse_cnt = 0;
				pulse_d = 1'b0;
			end
			if (in_burst)
			begin
				if (vt == burst_q[0].time_start +
					64'(burst_q[0].n_pulse) * {32'd0, burst_q[0].tp})
				begin
					check_flag(busy, 1'b0, "busy after last period");
					check_time(64'(pulse_cnt), 64'(burst_q[0].n_pulse), "pulse count");
					in_burst = 1'b0;
					void'(burst_q.pop_front());
					bursts_done++;
				end
				else
				begin
					e = ref_model(burst_q[0], vt);
					check_flag(busy, 1'b1, "busy in burst");
					check_gate(pulse, e.pulse, "pulse");
					check_gate(blank, e.blank, "blank");
					check_freq(freq_word, e.freq, "freq_word");
					if (pulse && !pulse_d)
						pulse_cnt++;
					pulse_d = pulse;
				end
				vt = vt + 64'd1;
			end
			else if (busy)
			begin
				check_gate(pulse, 1'b0, "pulse while armed");
				check_gate(blank, 1'b0, "blank while armed");
			end
		end
	end

	initial
	begin : main
		radar_pkg::frame_t f;
		radar_pkg::frame_t g;
		int n;
		clk = 1'b0;
		rst = 1'b1;
		sclk = 1'b0;
		cs = 1'b1;
		mosi = 1'b0;
		seed = 30;
		value_errors = 0;
		timeout_errors = 0;
		timed_out = 1'b0;
		in_burst = 1'b0;
		vt = '0;
		pulse_cnt = 0;
		pulse_d = 1'b0;
		bursts_done = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// outputs idle after reset
		@(negedge clk);
		check_flag(busy, 1'b0, "busy after reset");
		check_gate(pulse, 1'b0, "pulse after reset");
		check_gate(blank, 1'b0, "blank after reset");
		check_flag(time_update, 1'b0, "time_update after reset");
		check_flag(frame_error, 1'b0, "frame_error after reset");
		check_flag(cmd_reject, 1'b0, "cmd_reject after reset");
		check_freq(freq_word, 48'd0, "freq_word after reset");

		// preset and a fixed frequency burst
		make_frame(radar_pkg::type_fixed, f);
		accept_frame(f);
		for (n = 1; n <= 100; n++)
		begin
			@(negedge clk);
			check_time(sys_time, f.sys_time + 64'(n), "sys_time after preset");
			check_flag(time_update, 1'b0, "time_update after preset");
		end
		wait_bursts(1, 2000);

		make_frame(radar_pkg::type_chirp, f);
		accept_frame(f);
		wait_bursts(2, 2000);
		make_frame(radar_pkg::type_hop, f);
		accept_frame(f);
		wait_bursts(3, 2000);

		// inconsistent commands
		make_frame(radar_pkg::type_fixed, g);
		g.ti = g.tp;
		send_frame(g, radar_pkg::frame_bits);
		wait_strobe(1, 50, "cmd_reject for ti not below tp");
		watch_quiet(200);
		make_frame(radar_pkg::type_fixed, g);
		g.n_pulse = '0;
		send_frame(g, radar_pkg::frame_bits);
		wait_strobe(1, 50, "cmd_reject for zero n_pulse");
		watch_quiet(200);
		make_frame(radar_pkg::type_fixed, g);
		g.pulse_type = 8'd7;
		send_frame(g, radar_pkg::frame_bits);
		wait_strobe(1, 50, "cmd_reject for unknown type");
		watch_quiet(200);

		// framing errors
		send_frame(f, radar_pkg::frame_bits - 1);
		wait_strobe(2, 50, "frame_error for short frame");
		watch_quiet(200);
		send_frame(f, radar_pkg::frame_bits + 1);
		wait_strobe(2, 50, "frame_error for long frame");
		watch_quiet(200);

		// second command lands while the first burst runs
		make_frame(radar_pkg::type_fixed, f);
		f.ti = 32'd50;
		f.tblank1 = 32'd10;
		f.tblank2 = 32'd10;
		f.tp = 32'd500;
		f.n_pulse = 16'd10;
		f.time_start = f.sys_time + 64'd40;
		make_frame(radar_pkg::type_hop, g);
		g.time_start = g.sys_time + 64'd6000;
		accept_frame(f);
		accept_frame(g);
		if (!timed_out)
			check_flag(in_burst, 1'b1, "first burst running at second preset");
		wait_bursts(5, 15000);

		$display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
src/radar_pkg.sv
src/spi_frame_rx.sv
src/cmd_decode.sv
src/cmd_shadow.sv
src/pulse_sequencer.sv
src/freq_sweep.sv
src/radar_ctrl_top.sv
tests/radar_ctrl_asserts.sv
tests/radar_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= radar_ctrl_tb
FLIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard src/*.sv) $(wildcard tests/*.sv)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
